//--- per2axi_pkg.sv
/*
  shared widths, buffer depths and channel payloads of the peripheral to AXI bridge
  imported by the bridge modules; the payload types size the channel buffers
*/

package per2axi_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int unsigned PER_ADDR_W = 32;  // peripheral and AXI address
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned PER_ID_W   = 5;   // id is passed through unchanged to AXI

  // buffer depths and outstanding counter width
  localparam int unsigned REQ_BUF_DEPTH  = 4;
  localparam int unsigned RESP_BUF_DEPTH = 2;
  localparam int unsigned CNT_W          = 4;

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  typedef struct packed {
    logic [PER_ADDR_W-1:0] addr;
    logic [PER_ID_W-1:0]   id;
  } addr_chan_t;  // shared by AW and AR

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [PER_ID_W-1:0] id;
    logic                last;
  } r_chan_t;

  typedef struct packed {
    logic [PER_ID_W-1:0] id;
  } b_chan_t;

endpackage

//--- axi_spill_fifo.sv
/*
  fall-through FIFO with valid/ready on both sides, used as an elastic channel buffer
  an empty buffer shows its input at once and passes it on without storing it
  when the beat is taken in the same cycle
*/

module axi_spill_fifo #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned OCC_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [OCC_W-1:0] occ_q;
  payload_t         mem_q [DEPTH];

  logic empty;
  logic push;
  logic pop;
  logic bypass;
  logic wr_en;
  logic rd_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty   = (occ_q == '0);
  assign ready_o = (occ_q != OCC_W'(DEPTH));
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  assign push   = valid_i & ready_o;
  assign pop    = valid_o & ready_i;
  assign bypass = empty & push & pop;  // beat goes straight through
  assign wr_en  = push & ~bypass;
  assign rd_en  = pop & ~bypass;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      occ_q    <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (rd_en) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (wr_en && !rd_en) begin
        occ_q <= occ_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        occ_q <= occ_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- per2axi_req_channel.sv
/*
  turns a peripheral request into AXI buffer pushes
  a write pushes one AW and one W beat, a read pushes one AR beat,
  and the grant holds only while all three request buffers have room
*/

module per2axi_req_channel (
  input  logic                            per_req_i,
  input  logic [per2axi_pkg::PER_ADDR_W-1:0] per_addr_i,
  input  logic                            per_wen_i,  // low for a write
  input  logic [per2axi_pkg::DATA_W-1:0]  per_wdata_i,
  input  logic [per2axi_pkg::STRB_W-1:0]  per_be_i,
  input  logic [per2axi_pkg::PER_ID_W-1:0] per_id_i,
  output logic                            per_gnt_o,
  output logic                            aw_valid_o,
  input  logic                            aw_ready_i,
  output per2axi_pkg::addr_chan_t         aw_data_o,
  output logic                            w_valid_o,
  input  logic                            w_ready_i,
  output per2axi_pkg::w_chan_t            w_data_o,
  output logic                            ar_valid_o,
  input  logic                            ar_ready_i,
  output per2axi_pkg::addr_chan_t         ar_data_o
);

  logic accept;

  // grant looks at all three buffers so either request kind can go
  assign per_gnt_o = aw_ready_i & w_ready_i & ar_ready_i;
  assign accept    = per_req_i & per_gnt_o;

  assign aw_valid_o = accept & ~per_wen_i;
  assign w_valid_o  = accept & ~per_wen_i;
  assign ar_valid_o = accept & per_wen_i;

  assign aw_data_o = '{addr: per_addr_i, id: per_id_i};
  assign ar_data_o = '{addr: per_addr_i, id: per_id_i};

  // single beat bursts, so every W beat is the last one
  assign w_data_o = '{data: per_wdata_i, strb: per_be_i, last: 1'b1};

endmodule

//--- per2axi_res_channel.sv
/*
  merges buffered R and B beats onto the peripheral response port
  R wins when both are waiting, and only the selected buffer is popped
*/

module per2axi_res_channel (
  input  logic                             per_r_ready_i,
  output logic                             per_r_valid_o,
  output logic [per2axi_pkg::PER_ID_W-1:0] per_r_id_o,
  output logic [per2axi_pkg::DATA_W-1:0]   per_r_rdata_o,
  input  logic                             r_valid_i,
  input  per2axi_pkg::r_chan_t             r_data_i,
  output logic                             r_ready_o,
  input  logic                             b_valid_i,
  input  per2axi_pkg::b_chan_t             b_data_i,
  output logic                             b_ready_o
);

  // the response strobe only fires while the peripheral can take it
  assign per_r_valid_o = per_r_ready_i & (r_valid_i | b_valid_i);

  assign r_ready_o = per_r_ready_i;
  assign b_ready_o = per_r_ready_i & ~r_valid_i;  // B waits behind a pending R

  always_comb begin
    if (r_valid_i) begin
      per_r_id_o    = r_data_i.id;
      per_r_rdata_o = r_data_i.data;
    end else begin
      per_r_id_o    = b_data_i.id;
      per_r_rdata_o = '0;  // write responses carry no data
    end
  end

endmodule

//--- per2axi_busy_unit.sv
/*
  tracks outstanding AXI writes and reads and raises busy while any is open
  counter 0 follows AW pushes against B pops, counter 1 AR pushes against last R pops
*/

module per2axi_busy_unit (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_xfer_i,
  input  logic b_xfer_i,
  input  logic ar_xfer_i,
  input  logic r_last_xfer_i,
  output logic busy_o
);

  import per2axi_pkg::*;

  logic [1:0]       inc;
  logic [1:0]       dec;
  logic [CNT_W-1:0] cnt_q [2];

  assign inc = {ar_xfer_i, aw_xfer_i};
  assign dec = {r_last_xfer_i, b_xfer_i};

  for (genvar i = 0; i < 2; i++) begin : gen_cnt
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (inc[i] && !dec[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end else if (dec[i] && !inc[i]) begin
        cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
  end

  assign busy_o = (cnt_q[0] != '0) | (cnt_q[1] != '0);

endmodule

//--- per2axi.sv
/*
  peripheral to AXI bridge top level
  requests go through the request channel into the AW, W and AR buffers,
  R and B come back through their buffers and the response channel,
  and the busy unit watches the transfers in between
*/

module per2axi (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // peripheral request
  input  logic                             per_req_i,
  input  logic [per2axi_pkg::PER_ADDR_W-1:0] per_addr_i,
  input  logic                             per_wen_i,
  input  logic [per2axi_pkg::DATA_W-1:0]   per_wdata_i,
  input  logic [per2axi_pkg::STRB_W-1:0]   per_be_i,
  input  logic [per2axi_pkg::PER_ID_W-1:0] per_id_i,
  output logic                             per_gnt_o,
  // peripheral response
  input  logic                             per_r_ready_i,
  output logic                             per_r_valid_o,
  output logic [per2axi_pkg::PER_ID_W-1:0] per_r_id_o,
  output logic [per2axi_pkg::DATA_W-1:0]   per_r_rdata_o,
  output logic                             busy_o,
  // AXI master
  output logic                             axi_aw_valid_o,
  output logic [per2axi_pkg::PER_ADDR_W-1:0] axi_aw_addr_o,
  output logic [per2axi_pkg::PER_ID_W-1:0] axi_aw_id_o,
  input  logic                             axi_aw_ready_i,
  output logic                             axi_w_valid_o,
  output logic [per2axi_pkg::DATA_W-1:0]   axi_w_data_o,
  output logic [per2axi_pkg::STRB_W-1:0]   axi_w_strb_o,
  output logic                             axi_w_last_o,
  input  logic                             axi_w_ready_i,
  output logic                             axi_ar_valid_o,
  output logic [per2axi_pkg::PER_ADDR_W-1:0] axi_ar_addr_o,
  output logic [per2axi_pkg::PER_ID_W-1:0] axi_ar_id_o,
  input  logic                             axi_ar_ready_i,
  input  logic                             axi_r_valid_i,
  input  logic [per2axi_pkg::DATA_W-1:0]   axi_r_data_i,
  input  logic [per2axi_pkg::PER_ID_W-1:0] axi_r_id_i,
  input  logic                             axi_r_last_i,
  output logic                             axi_r_ready_o,
  input  logic                             axi_b_valid_i,
  input  logic [per2axi_pkg::PER_ID_W-1:0] axi_b_id_i,
  output logic                             axi_b_ready_o
);

  import per2axi_pkg::*;

  logic       aw_push_valid;
  logic       aw_push_ready;
  addr_chan_t aw_push_data;
  addr_chan_t aw_out;
  logic       w_push_valid;
  logic       w_push_ready;
  w_chan_t    w_push_data;
  w_chan_t    w_out;
  logic       ar_push_valid;
  logic       ar_push_ready;
  addr_chan_t ar_push_data;
  addr_chan_t ar_out;

  r_chan_t    r_in;
  logic       r_pop_valid;
  logic       r_pop_ready;
  r_chan_t    r_pop_data;
  b_chan_t    b_in;
  logic       b_pop_valid;
  logic       b_pop_ready;
  b_chan_t    b_pop_data;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  per2axi_req_channel i_req_channel (
    .per_req_i,
    .per_addr_i,
    .per_wen_i,
    .per_wdata_i,
    .per_be_i,
    .per_id_i,
    .per_gnt_o,
    .aw_valid_o(aw_push_valid),
    .aw_ready_i(aw_push_ready),
    .aw_data_o (aw_push_data),
    .w_valid_o (w_push_valid),
    .w_ready_i (w_push_ready),
    .w_data_o  (w_push_data),
    .ar_valid_o(ar_push_valid),
    .ar_ready_i(ar_push_ready),
    .ar_data_o (ar_push_data)
  );

  axi_spill_fifo #(.DEPTH(REQ_BUF_DEPTH), .payload_t(addr_chan_t)) i_aw_buf (
    .clk_i,
    .rst_ni,
    .valid_i(aw_push_valid),
    .ready_o(aw_push_ready),
    .data_i (aw_push_data),
    .valid_o(axi_aw_valid_o),
    .ready_i(axi_aw_ready_i),
    .data_o (aw_out)
  );

  axi_spill_fifo #(.DEPTH(REQ_BUF_DEPTH), .payload_t(w_chan_t)) i_w_buf (
    .clk_i,
    .rst_ni,
    .valid_i(w_push_valid),
    .ready_o(w_push_ready),
    .data_i (w_push_data),
    .valid_o(axi_w_valid_o),
    .ready_i(axi_w_ready_i),
    .data_o (w_out)
  );

  axi_spill_fifo #(.DEPTH(REQ_BUF_DEPTH), .payload_t(addr_chan_t)) i_ar_buf (
    .clk_i,
    .rst_ni,
    .valid_i(ar_push_valid),
    .ready_o(ar_push_ready),
    .data_i (ar_push_data),
    .valid_o(axi_ar_valid_o),
    .ready_i(axi_ar_ready_i),
    .data_o (ar_out)
  );

  assign axi_aw_addr_o = aw_out.addr;
  assign axi_aw_id_o   = aw_out.id;
  assign axi_w_data_o  = w_out.data;
  assign axi_w_strb_o  = w_out.strb;
  assign axi_w_last_o  = w_out.last;
  assign axi_ar_addr_o = ar_out.addr;
  assign axi_ar_id_o   = ar_out.id;

  // --------------------------------------------------
  // response side
  // --------------------------------------------------
  assign r_in = '{data: axi_r_data_i, id: axi_r_id_i, last: axi_r_last_i};
  assign b_in = '{id: axi_b_id_i};

  axi_spill_fifo #(.DEPTH(RESP_BUF_DEPTH), .payload_t(r_chan_t)) i_r_buf (
    .clk_i,
    .rst_ni,
    .valid_i(axi_r_valid_i),
    .ready_o(axi_r_ready_o),
    .data_i (r_in),
    .valid_o(r_pop_valid),
    .ready_i(r_pop_ready),
    .data_o (r_pop_data)
  );

  axi_spill_fifo #(.DEPTH(RESP_BUF_DEPTH), .payload_t(b_chan_t)) i_b_buf (
    .clk_i,
    .rst_ni,
    .valid_i(axi_b_valid_i),
    .ready_o(axi_b_ready_o),
    .data_i (b_in),
    .valid_o(b_pop_valid),
    .ready_i(b_pop_ready),
    .data_o (b_pop_data)
  );

  per2axi_res_channel i_res_channel (
    .per_r_ready_i,
    .per_r_valid_o,
    .per_r_id_o,
    .per_r_rdata_o,
    .r_valid_i(r_pop_valid),
    .r_data_i (r_pop_data),
    .r_ready_o(r_pop_ready),
    .b_valid_i(b_pop_valid),
    .b_data_i (b_pop_data),
    .b_ready_o(b_pop_ready)
  );

  // a request counts as open from its push until its response leaves the buffer
  per2axi_busy_unit i_busy_unit (
    .clk_i,
    .rst_ni,
    .aw_xfer_i    (aw_push_valid & aw_push_ready),
    .b_xfer_i     (b_pop_valid & b_pop_ready),
    .ar_xfer_i    (ar_push_valid & ar_push_ready),
    .r_last_xfer_i(r_pop_valid & r_pop_ready & r_pop_data.last),
    .busy_o
  );

endmodule

//--- tb_axi_slave.sv
/*
  behavioral AXI memory slave for the bridge testbench
  64 words, strobed writes, B and R returned in accept order after random delays
  stall_i holds every request ready low
*/

module tb_axi_slave (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stall_i,
  input  logic        aw_valid_i,
  input  logic [31:0] aw_addr_i,
  input  logic [4:0]  aw_id_i,
  output logic        aw_ready_o,
  input  logic        w_valid_i,
  input  logic [31:0] w_data_i,
  input  logic [3:0]  w_strb_i,
  input  logic        w_last_i,
  output logic        w_ready_o,
  input  logic        ar_valid_i,
  input  logic [31:0] ar_addr_i,
  input  logic [4:0]  ar_id_i,
  output logic        ar_ready_o,
  output logic        r_valid_o,
  output logic [31:0] r_data_o,
  output logic [4:0]  r_id_o,
  output logic        r_last_o,
  input  logic        r_ready_i,
  output logic        b_valid_o,
  output logic [4:0]  b_id_o,
  input  logic        b_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] mem [64];
  logic [31:0] aw_addr_q[$];
  logic [4:0]  aw_id_q[$];
  logic [31:0] w_data_q[$];
  logic [3:0]  w_strb_q[$];
  bit          rsp_read_q[$];
  logic [4:0]  rsp_id_q[$];
  logic [31:0] rsp_data_q[$];
  int          delay;
  bit          pending;
  logic [5:0]  idx;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = (i * 32'h9e3779b1) ^ 32'hc0de0000;  // differs in every address bit
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_id_o     <= '0;
      r_last_o   <= 1'b0;
      b_valid_o  <= 1'b0;
      b_id_o     <= '0;
      delay = 0;
    end else begin
      if (aw_valid_i && aw_ready_o) begin
        aw_addr_q.push_back(aw_addr_i);
        aw_id_q.push_back(aw_id_i);
      end
      // a burst's data is taken with its last beat
      if (w_valid_i && w_ready_o && w_last_i) begin
        w_data_q.push_back(w_data_i);
        w_strb_q.push_back(w_strb_i);
      end
      if (ar_valid_i && ar_ready_o) begin
        rsp_read_q.push_back(1'b1);
        rsp_id_q.push_back(ar_id_i);
        rsp_data_q.push_back(mem[ar_addr_i[7:2]]);
      end
      // a write completes once both its address and data have arrived
      while (aw_addr_q.size() > 0 && w_data_q.size() > 0) begin
        idx = aw_addr_q[0][7:2];
        for (int b = 0; b < 4; b++) begin
          if (w_strb_q[0][b]) mem[idx][8*b +: 8] = w_data_q[0][8*b +: 8];
        end
        rsp_read_q.push_back(1'b0);
        rsp_id_q.push_back(aw_id_q.pop_front());
        rsp_data_q.push_back('0);
        void'(aw_addr_q.pop_front());
        void'(w_data_q.pop_front());
        void'(w_strb_q.pop_front());
      end

      if (r_valid_o && r_ready_i) r_valid_o <= 1'b0;
      if (b_valid_o && b_ready_i) b_valid_o <= 1'b0;
      pending = (r_valid_o && !r_ready_i) || (b_valid_o && !b_ready_i);

      if (!pending && rsp_id_q.size() > 0) begin
        if (delay == 0) begin
          if (rsp_read_q.pop_front()) begin
            r_valid_o <= 1'b1;
            r_id_o    <= rsp_id_q.pop_front();
            r_data_o  <= rsp_data_q.pop_front();
            r_last_o  <= 1'b1;
          end else begin
            b_valid_o <= 1'b1;
            b_id_o    <= rsp_id_q.pop_front();
            void'(rsp_data_q.pop_front());
          end
          delay = $urandom % 4;
        end else begin
          delay--;
        end
      end

      aw_ready_o <= !stall_i && ($urandom % 4 != 0);
      w_ready_o  <= !stall_i && ($urandom % 4 != 0);
      ar_ready_o <= !stall_i && ($urandom % 4 != 0);
    end
  end

endmodule

//--- tb_per2axi_assert.sv
/*
  AXI and peripheral handshake assertions, bound into the bridge top level
*/

module tb_per2axi_assert (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        axi_aw_valid_o,
  input logic        axi_aw_ready_i,
  input logic [31:0] axi_aw_addr_o,
  input logic [4:0]  axi_aw_id_o,
  input logic        axi_w_valid_o,
  input logic        axi_w_ready_i,
  input logic [31:0] axi_w_data_o,
  input logic [3:0]  axi_w_strb_o,
  input logic        axi_w_last_o,
  input logic        axi_ar_valid_o,
  input logic        axi_ar_ready_i,
  input logic [31:0] axi_ar_addr_o,
  input logic [4:0]  axi_ar_id_o,
  input logic        per_r_valid_o,
  input logic        per_r_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_aw_valid_o && !axi_aw_ready_i |=>
      axi_aw_valid_o && $stable(axi_aw_addr_o) && $stable(axi_aw_id_o))
    else $error("AW beat dropped or changed before ready");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && !axi_w_ready_i |=>
      axi_w_valid_o && $stable(axi_w_data_o) && $stable(axi_w_strb_o))
    else $error("W beat dropped or changed before ready");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_ar_valid_o && !axi_ar_ready_i |=>
      axi_ar_valid_o && $stable(axi_ar_addr_o) && $stable(axi_ar_id_o))
    else $error("AR beat dropped or changed before ready");

  w_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o |-> axi_w_last_o)
    else $error("W beat without last");

  rsp_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    per_r_valid_o |-> per_r_ready_i)
    else $error("response strobe while peripheral not ready");

endmodule

bind per2axi tb_per2axi_assert u_assert (.*);

//--- tb_per2axi.sv
/*
  testbench top for the peripheral to AXI bridge
  drives requests, predicts responses with its own memory model and
  compares every AXI request beat in order and every response in order per kind
*/

module tb_per2axi;

  timeunit 1ns;
  timeprecision 100ps;

  import per2axi_pkg::*;

  localparam int unsigned TIMEOUT = 400;

  logic        clk_i, rst_ni, stall;
  logic        per_req_i, per_wen_i, per_gnt_o, per_r_ready_i, per_r_valid_o, busy_o;
  logic [31:0] per_addr_i, per_wdata_i, per_r_rdata_o;
  logic [3:0]  per_be_i;
  logic [4:0]  per_id_i, per_r_id_o;
  logic        aw_valid, aw_ready, w_valid, w_ready, w_last, ar_valid, ar_ready;
  logic        r_valid, r_ready, r_last, b_valid, b_ready;
  logic [31:0] aw_addr, w_data, ar_addr, r_data;
  logic [3:0]  w_strb;
  logic [4:0]  aw_id, ar_id, r_id, b_id;

  logic [31:0] ref_mem [64];
  logic [4:0]  exp_wr_id_q[$];
  logic [4:0]  exp_rd_id_q[$];
  logic [31:0] exp_rd_data_q[$];
  logic [36:0] exp_aw_q[$];
  logic [35:0] exp_w_q[$];
  logic [36:0] exp_ar_q[$];
  logic [4:0]  next_id;
  int          errors, checks, test_errors;

  per2axi DUT (
    .clk_i, .rst_ni, .per_req_i, .per_addr_i, .per_wen_i, .per_wdata_i, .per_be_i,
    .per_id_i, .per_gnt_o, .per_r_ready_i, .per_r_valid_o, .per_r_id_o, .per_r_rdata_o,
    .busy_o,
    .axi_aw_valid_o(aw_valid), .axi_aw_addr_o(aw_addr), .axi_aw_id_o(aw_id),
    .axi_aw_ready_i(aw_ready), .axi_w_valid_o(w_valid), .axi_w_data_o(w_data),
    .axi_w_strb_o(w_strb), .axi_w_last_o(w_last), .axi_w_ready_i(w_ready),
    .axi_ar_valid_o(ar_valid), .axi_ar_addr_o(ar_addr), .axi_ar_id_o(ar_id),
    .axi_ar_ready_i(ar_ready), .axi_r_valid_i(r_valid), .axi_r_data_i(r_data),
    .axi_r_id_i(r_id), .axi_r_last_i(r_last), .axi_r_ready_o(r_ready),
    .axi_b_valid_i(b_valid), .axi_b_id_i(b_id), .axi_b_ready_o(b_ready)
  );

  tb_axi_slave u_slave (
    .clk_i, .rst_ni, .stall_i(stall),
    .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_id_i(aw_id), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_last_i(w_last),
    .w_ready_o(w_ready), .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_id_i(ar_id),
    .ar_ready_o(ar_ready), .r_valid_o(r_valid), .r_data_o(r_data), .r_id_o(r_id),
    .r_last_o(r_last), .r_ready_i(r_ready), .b_valid_o(b_valid), .b_id_o(b_id),
    .b_ready_i(b_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // byte-enable merge of a write into the old word
  function automatic logic [31:0] merge_word(logic [31:0] old, logic [31:0] wdata,
                                             logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("Checks failed");
    $finish;
  endtask

  // --------------------------------------------------
  // comparison of responses and AXI request beats
  // --------------------------------------------------
  always @(negedge clk_i) begin
    logic [36:0] a_exp;
    logic [35:0] w_exp;
    if (rst_ni && per_r_valid_o) begin
      // ids are unique among open requests and R may overtake B
      if (exp_wr_id_q.size() > 0 && per_r_id_o == exp_wr_id_q[0]) begin
        void'(exp_wr_id_q.pop_front());
        check("per_r_rdata_o", per_r_rdata_o, '0);
      end else if (exp_rd_id_q.size() > 0 && per_r_id_o == exp_rd_id_q[0]) begin
        void'(exp_rd_id_q.pop_front());
        check("per_r_rdata_o", per_r_rdata_o, exp_rd_data_q.pop_front());
      end else begin
        $display("response at %0t with id %h matches no open request", $time, per_r_id_o);
        errors++;
      end
    end
    if (rst_ni && aw_valid && aw_ready) begin
      a_exp = exp_aw_q.pop_front();
      check("axi_aw_addr_o", aw_addr, a_exp[36:5]);
      check("axi_aw_id_o", 32'(aw_id), 32'(a_exp[4:0]));
    end
    if (rst_ni && w_valid && w_ready) begin
      w_exp = exp_w_q.pop_front();
      check("axi_w_data_o", w_data, w_exp[35:4]);
      check("axi_w_strb_o", 32'(w_strb), 32'(w_exp[3:0]));
    end
    if (rst_ni && ar_valid && ar_ready) begin
      a_exp = exp_ar_q.pop_front();
      check("axi_ar_addr_o", ar_addr, a_exp[36:5]);
      check("axi_ar_id_o", 32'(ar_id), 32'(a_exp[4:0]));
    end
  end

  // drives one request; nothing is recorded for a request that is never granted
  task automatic issue(logic wen, logic [5:0] idx, logic [31:0] wdata, logic [3:0] be,
                       int max_wait, output bit granted);
    logic [4:0]  id;
    logic [31:0] old;
    id  = next_id;
    old = ref_mem[idx];
    next_id++;
    @(posedge clk_i);
    per_req_i   <= 1'b1;
    per_wen_i   <= wen;
    per_addr_i  <= {24'h0, idx, 2'b00};
    per_wdata_i <= wdata;
    per_be_i    <= be;
    per_id_i    <= id;
    if (!wen) begin
      ref_mem[idx] = merge_word(old, wdata, be);
      exp_wr_id_q.push_back(id);
      exp_aw_q.push_back({24'h0, idx, 2'b00, id});
      exp_w_q.push_back({wdata, be});
    end else begin
      exp_rd_id_q.push_back(id);
      exp_rd_data_q.push_back(old);
      exp_ar_q.push_back({24'h0, idx, 2'b00, id});
    end
    granted = 1'b0;
    for (int t = 0; t < max_wait && !granted; t++) begin
      @(negedge clk_i);
      granted = per_gnt_o;
      @(posedge clk_i);
    end
    per_req_i <= 1'b0;
    if (!granted) begin
      if (!wen) begin
        ref_mem[idx] = old;
        void'(exp_wr_id_q.pop_back());
        void'(exp_aw_q.pop_back());
        void'(exp_w_q.pop_back());
      end else begin
        void'(exp_rd_id_q.pop_back());
        void'(exp_rd_data_q.pop_back());
        void'(exp_ar_q.pop_back());
      end
    end
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) timeout_fail("all responses and busy low");
    end while (exp_wr_id_q.size() != 0 || exp_rd_id_q.size() != 0 || busy_o);
  endtask

  task automatic end_test(string name);
    $display("test %s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    bit ok;
    int n;
    logic [5:0]  idx;
    logic [31:0] wd;
    void'($urandom(32'h02a32141));
    for (int i = 0; i < 64; i++) ref_mem[i] = (i * 32'h9e3779b1) ^ 32'hc0de0000;
    {rst_ni, stall, per_req_i, per_wen_i, per_r_ready_i} = 5'b00011;
    {per_addr_i, per_wdata_i, per_be_i, per_id_i} = '0;
    next_id = '0;
    errors = 0;
    checks = 0;
    test_errors = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check("per_gnt_o", 32'(per_gnt_o), 32'd1);
    check("busy/valids", 32'({busy_o, per_r_valid_o, aw_valid, w_valid, ar_valid}), '0);
    end_test("reset");

    for (int k = 0; k < 8; k++) begin
      idx = 6'($urandom);
      wd  = $urandom;
      issue(1'b0, idx, wd, 4'($urandom), TIMEOUT, ok);
      if (!ok) timeout_fail("grant");
      @(negedge clk_i);
      check("busy_o", 32'(busy_o), 32'd1);  // write still open
      wait_idle();
      issue(1'b1, idx, '0, '0, TIMEOUT, ok);
      if (!ok) timeout_fail("grant");
      wait_idle();
    end
    end_test("write then read");

    // request buffers fill while the slave stalls
    stall = 1'b1;
    repeat (2) @(posedge clk_i);
    n = 0;
    for (int k = 0; k < REQ_BUF_DEPTH + 2; k++) begin
      issue(1'b0, 6'($urandom % 32), $urandom, 4'hf, 10, ok);
      if (ok) n++;
    end
    @(negedge clk_i);
    if (n > REQ_BUF_DEPTH || per_gnt_o) begin
      $display("grant still high after %0d stalled requests", n);
      errors++;
    end
    stall <= 1'b0;
    wait_idle();
    end_test("back-pressure");

    // writes stay in the lower half and reads in the upper half
    fork
      begin
        @(posedge clk_i);
        per_r_ready_i <= 1'b0;
        repeat (20 + $urandom % 40) @(posedge clk_i);
        per_r_ready_i <= 1'b1;
      end
      for (int k = 0; k < 16; k++) begin
        if ($urandom % 2) issue(1'b1, 6'(32 + $urandom % 32), '0, '0, TIMEOUT, ok);
        else issue(1'b0, 6'($urandom % 32), $urandom, 4'($urandom), TIMEOUT, ok);
        if (!ok) timeout_fail("grant");
      end
    join
    wait_idle();
    end_test("response stall");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
per2axi_pkg.sv
axi_spill_fifo.sv
per2axi_req_channel.sv
per2axi_res_channel.sv
per2axi_busy_unit.sv
per2axi.sv
tb_axi_slave.sv
tb_per2axi_assert.sv
tb_per2axi.sv

//--- Makefile
# Verilator build and run for the bridge testbench

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_per2axi
BUILD_DIR ?= build
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
